/* Makefile */
TOP = tb_csr_file

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f csr_file.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f csr_file.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* csr_atomic_check.sv */
// atomic read check
// checkpoints a CSR read and flags when the register changes before the read retires
`timescale 1ns/1ns

module csr_atomic_check (
  input  logic               clk,
  input  logic               reset,
  input  logic               rd_en_i,
  input  csr_pkg::csr_addr_t rd_addr_i,
  input  csr_pkg::csr_data_t rd_data_i,
  input  logic               commit_i,
  input  logic               flush_i,
  output csr_pkg::csr_addr_t chk_addr_o,
  input  csr_pkg::csr_data_t chk_cur_i,
  output logic               vio_o
);

  csr_pkg::csr_data_t chk_data;
  logic               chk_valid;

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      chk_addr_o <= rd_addr_i;
      chk_data   <= rd_data_i;
    end
  end

  // a new read wins over commit or flush at the same edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chk_valid <= 1'b0;
    end else if (rd_en_i) begin
      chk_valid <= 1'b1;
    end else if (flush_i || commit_i) begin
      chk_valid <= 1'b0;
    end
  end

  assign vio_o = chk_valid && (chk_cur_i != chk_data);

  // once the read retires or is squashed no violation may be reported
  a_no_vio_after_clear: assert property (@(posedge clk) disable iff (reset)
    (!rd_en_i && (flush_i || commit_i)) |=> !vio_o);

endmodule

/* csr_counters.sv */
// mcycle and minstret performance counters
// a committed CSR write replaces the increment for that cycle
`timescale 1ns/1ns

module csr_counters #(
  parameter int RETIRE_CNT_W = 3
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [RETIRE_CNT_W-1:0] retire_cnt_i,
  input  logic                    cmt_we_i,
  input  csr_pkg::csr_write_t     cmt_i,
  output csr_pkg::csr_data_t      mcycle_o,
  output csr_pkg::csr_data_t      minstret_o
);

  logic wr_mcycle;
  logic wr_minstret;

  // cycle and instret are read-only aliases and take no writes
  assign wr_mcycle   = cmt_we_i && (cmt_i.addr == csr_pkg::CSR_MCYCLE);
  assign wr_minstret = cmt_we_i && (cmt_i.addr == csr_pkg::CSR_MINSTRET);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mcycle_o   <= '0;
      minstret_o <= '0;
    end else begin
      mcycle_o   <= wr_mcycle ? cmt_i.data : mcycle_o + 64'd1;
      minstret_o <= wr_minstret ? cmt_i.data
                                : minstret_o + csr_pkg::csr_data_t'(retire_cnt_i);
    end
  end

endmodule

/* csr_file.f */
csr_pkg.sv
csr_write_stage.sv
csr_counters.sv
csr_machine_state.sv
csr_read_decode.sv
csr_atomic_check.sv
csr_file_top.sv
tb_csr_file.sv

/* csr_file_top.sv */
// machine-mode CSR file top level
// staged commit writes, counters, trap state, read port and atomic read check
`timescale 1ns/1ns

module csr_file_top #(
  parameter int RETIRE_CNT_W = 3
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wr_en_i,
  input  csr_pkg::csr_write_t     wr_i,
  input  logic                    commit_i,
  input  logic                    flush_i,
  input  logic                    rd_en_i,
  input  csr_pkg::csr_addr_t      rd_addr_i,
  input  logic [RETIRE_CNT_W-1:0] retire_cnt_i,
  input  logic                    exc_valid_i,
  input  csr_pkg::exc_info_t      exc_i,
  input  logic                    mret_i,
  input  logic                    irq_ext_i,
  input  logic                    irq_soft_i,
  input  logic                    irq_timer_i,
  input  csr_pkg::csr_data_t      hart_id_i,
  input  csr_pkg::csr_data_t      boot_vec_i,
  output csr_pkg::csr_data_t      rd_data_o,
  output logic                    atomic_vio_o,
  output logic                    irq_pending_o,
  output csr_pkg::csr_data_t      epc_o,
  output csr_pkg::csr_data_t      evec_o,
  output csr_pkg::priv_lvl_e      priv_o
);

  logic                cmt_we;
  csr_pkg::csr_write_t cmt;
  csr_pkg::csr_data_t  mcycle;
  csr_pkg::csr_data_t  minstret;
  csr_pkg::csr_state_t ms_state;
  csr_pkg::csr_state_t state;
  csr_pkg::csr_addr_t  chk_addr;
  csr_pkg::csr_data_t  chk_cur;

  csr_write_stage u_write_stage (
    .clk      (clk),
    .reset    (reset),
    .wr_en_i  (wr_en_i),
    .wr_i     (wr_i),
    .commit_i (commit_i),
    .flush_i  (flush_i),
    .cmt_we_o (cmt_we),
    .cmt_o    (cmt)
  );

  csr_counters #(
    .RETIRE_CNT_W (RETIRE_CNT_W)
  ) u_counters (
    .clk          (clk),
    .reset        (reset),
    .retire_cnt_i (retire_cnt_i),
    .cmt_we_i     (cmt_we),
    .cmt_i        (cmt),
    .mcycle_o     (mcycle),
    .minstret_o   (minstret)
  );

  csr_machine_state u_machine_state (
    .clk           (clk),
    .reset         (reset),
    .boot_vec_i    (boot_vec_i),
    .cmt_we_i      (cmt_we),
    .cmt_i         (cmt),
    .exc_valid_i   (exc_valid_i),
    .exc_i         (exc_i),
    .mret_i        (mret_i),
    .irq_ext_i     (irq_ext_i),
    .irq_soft_i    (irq_soft_i),
    .irq_timer_i   (irq_timer_i),
    .state_o       (ms_state),
    .irq_pending_o (irq_pending_o),
    .epc_o         (epc_o),
    .evec_o        (evec_o),
    .priv_o        (priv_o)
  );

  // complete architectural state with the counter values
  always_comb begin
    state          = ms_state;
    state.mcycle   = mcycle;
    state.minstret = minstret;
  end

  csr_read_decode u_rd_decode (
    .addr_i    (rd_addr_i),
    .state_i   (state),
    .hart_id_i (hart_id_i),
    .data_o    (rd_data_o)
  );

  // second decoder tracks the current value of the checkpointed CSR
  csr_read_decode u_chk_decode (
    .addr_i    (chk_addr),
    .state_i   (state),
    .hart_id_i (hart_id_i),
    .data_o    (chk_cur)
  );

  csr_atomic_check u_atomic_check (
    .clk        (clk),
    .reset      (reset),
    .rd_en_i    (rd_en_i),
    .rd_addr_i  (rd_addr_i),
    .rd_data_i  (rd_data_o),
    .commit_i   (commit_i),
    .flush_i    (flush_i),
    .chk_addr_o (chk_addr),
    .chk_cur_i  (chk_cur),
    .vio_o      (atomic_vio_o)
  );

endmodule

/* csr_machine_state.sv */
// machine-mode trap state: privilege, mstatus, mie, mtvec, mscratch, mepc, mcause, mtval
// handles committed writes, trap entry, mret and the interrupt-pending output
`timescale 1ns/1ns

module csr_machine_state (
  input  logic                clk,
  input  logic                reset,
  input  csr_pkg::csr_data_t  boot_vec_i,
  input  logic                cmt_we_i,
  input  csr_pkg::csr_write_t cmt_i,
  input  logic                exc_valid_i,
  input  csr_pkg::exc_info_t  exc_i,
  input  logic                mret_i,
  input  logic                irq_ext_i,
  input  logic                irq_soft_i,
  input  logic                irq_timer_i,
  output csr_pkg::csr_state_t state_o,
  output logic                irq_pending_o,
  output csr_pkg::csr_data_t  epc_o,
  output csr_pkg::csr_data_t  evec_o,
  output csr_pkg::priv_lvl_e  priv_o
);

  csr_pkg::priv_lvl_e priv_q, priv_d;
  csr_pkg::mstatus_t  mstatus_q, mstatus_d;
  csr_pkg::csr_data_t mie_q, mie_d;
  csr_pkg::csr_data_t mtvec_q, mtvec_d;
  csr_pkg::csr_data_t mscratch_q, mscratch_d;
  csr_pkg::csr_data_t mepc_q, mepc_d;
  csr_pkg::csr_data_t mcause_q, mcause_d;
  csr_pkg::csr_data_t mtval_q, mtval_d;
  csr_pkg::csr_data_t mip;
  csr_pkg::csr_data_t wdata;

  assign wdata = cmt_i.data;

  // mip follows the interrupt lines and is not writable
  always_comb begin
    mip                    = '0;
    mip[csr_pkg::IRQ_SOFT]  = irq_soft_i;
    mip[csr_pkg::IRQ_TIMER] = irq_timer_i;
    mip[csr_pkg::IRQ_EXT]   = irq_ext_i;
  end

  always_comb begin
    priv_d     = priv_q;
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mtvec_d    = mtvec_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    if (cmt_we_i) begin
      case (cmt_i.addr)
        csr_pkg::CSR_MSTATUS: begin
          mstatus_d.mie  = wdata[3];
          mstatus_d.mpie = wdata[7];
          // unsupported modes in MPP fall back to U
          mstatus_d.mpp  = (wdata[12:11] == 2'b11) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
        end
        csr_pkg::CSR_MIE:      mie_d      = wdata & csr_pkg::MIE_MASK;
        csr_pkg::CSR_MTVEC:    mtvec_d    = {wdata[63:2], 1'b0, wdata[0]};
        csr_pkg::CSR_MSCRATCH: mscratch_d = wdata;
        csr_pkg::CSR_MEPC:     mepc_d     = {wdata[63:1], 1'b0};
        csr_pkg::CSR_MCAUSE:   mcause_d   = wdata;
        csr_pkg::CSR_MTVAL:    mtval_d    = wdata;
        default: ;
      endcase
    end
    // trap entry and return take priority over a committed mstatus write
    if (exc_valid_i) begin
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mstatus_d.mpp  = priv_q;
      priv_d         = csr_pkg::PRIV_M;
      mepc_d         = exc_i.pc;
      mcause_d       = csr_pkg::csr_data_t'(exc_i.cause);
      case (exc_i.cause)
        csr_pkg::CAUSE_MISALIGNED_FETCH, csr_pkg::CAUSE_FAULT_FETCH:  mtval_d = exc_i.pc;
        csr_pkg::CAUSE_MISALIGNED_LOAD, csr_pkg::CAUSE_FAULT_LOAD:    mtval_d = exc_i.ld_addr;
        csr_pkg::CAUSE_MISALIGNED_STORE, csr_pkg::CAUSE_FAULT_STORE:  mtval_d = exc_i.st_addr;
        default: mtval_d = mtval_q;
      endcase
    end else if (mret_i) begin
      priv_d         = mstatus_q.mpp;
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
      mstatus_d.mpp  = csr_pkg::PRIV_U;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      priv_q     <= csr_pkg::PRIV_M;
      mstatus_q  <= '0;
      mie_q      <= '0;
      mtvec_q    <= boot_vec_i;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      priv_q     <= priv_d;
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mtvec_q    <= mtvec_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
    end
  end

  // U mode always takes enabled interrupts, M mode also needs mstatus.MIE
  assign irq_pending_o = (|(mie_q & mip)) &&
                         ((priv_q != csr_pkg::PRIV_M) || mstatus_q.mie);

  assign epc_o  = mepc_q;
  assign evec_o = {mtvec_q[63:2], 2'b00};
  assign priv_o = priv_q;

  // counter fields are merged in at the top level
  always_comb begin
    state_o          = '0;
    state_o.mstatus  = mstatus_q;
    state_o.mie      = mie_q;
    state_o.mip      = mip;
    state_o.mtvec    = mtvec_q;
    state_o.mscratch = mscratch_q;
    state_o.mepc     = mepc_q;
    state_o.mcause   = mcause_q;
    state_o.mtval    = mtval_q;
    state_o.priv     = priv_q;
  end

  // retire logic never commits an exception and an mret together
  a_exc_mret_excl: assert property (@(posedge clk) disable iff (reset)
    !(exc_valid_i && mret_i));

  a_priv_legal: assert property (@(posedge clk) disable iff (reset)
    priv_q inside {csr_pkg::PRIV_U, csr_pkg::PRIV_M});

endmodule

/* csr_pkg.sv */
// shared types and constants for the machine-mode CSR file
// widths, CSR addresses, masks, privilege levels and packed structs
package csr_pkg;

  parameter int CSR_XLEN = 64;

  typedef logic [11:0]         csr_addr_t;
  typedef logic [CSR_XLEN-1:0] csr_data_t;
  typedef logic [3:0]          exc_cause_t;

  // only user and machine mode exist
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  typedef struct packed {
    csr_addr_t addr;
    csr_data_t data;
  } csr_write_t;

  typedef struct packed {
    exc_cause_t cause;
    csr_data_t  pc;
    csr_data_t  ld_addr;
    csr_data_t  st_addr;
  } exc_info_t;

  // architectural mstatus bits 3, 7 and 12..11
  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

  typedef struct packed {
    mstatus_t  mstatus;
    csr_data_t mie;
    csr_data_t mip;
    csr_data_t mtvec;
    csr_data_t mscratch;
    csr_data_t mepc;
    csr_data_t mcause;
    csr_data_t mtval;
    csr_data_t mcycle;
    csr_data_t minstret;
    priv_lvl_e priv;
  } csr_state_t;

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_MIP       = 12'h344;
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_CYCLE     = 12'hC00;
  localparam csr_addr_t CSR_INSTRET   = 12'hC02;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  // interrupt bit positions in mip and mie
  localparam int IRQ_SOFT  = 3;
  localparam int IRQ_TIMER = 7;
  localparam int IRQ_EXT   = 11;

  localparam csr_data_t MIE_MASK = 64'h0000_0000_0000_0888;
  // MXL = 2 (RV64), extensions I and M
  localparam csr_data_t MISA_VAL = 64'h8000_0000_0000_1100;

  localparam exc_cause_t CAUSE_MISALIGNED_FETCH = 4'd0;
  localparam exc_cause_t CAUSE_FAULT_FETCH      = 4'd1;
  localparam exc_cause_t CAUSE_MISALIGNED_LOAD  = 4'd4;
  localparam exc_cause_t CAUSE_FAULT_LOAD       = 4'd5;
  localparam exc_cause_t CAUSE_MISALIGNED_STORE = 4'd6;
  localparam exc_cause_t CAUSE_FAULT_STORE      = 4'd7;

endpackage

/* csr_read_decode.sv */
// CSR read decoder
// maps a CSR address onto its current architectural value, unknown addresses read zero
`timescale 1ns/1ns

module csr_read_decode (
  input  csr_pkg::csr_addr_t  addr_i,
  input  csr_pkg::csr_state_t state_i,
  input  csr_pkg::csr_data_t  hart_id_i,
  output csr_pkg::csr_data_t  data_o
);

  csr_pkg::csr_data_t mstatus_val;

  // place the kept mstatus fields at their architectural positions
  always_comb begin
    mstatus_val        = '0;
    mstatus_val[3]     = state_i.mstatus.mie;
    mstatus_val[7]     = state_i.mstatus.mpie;
    mstatus_val[12:11] = state_i.mstatus.mpp;
  end

  always_comb begin
    case (addr_i)
      csr_pkg::CSR_MSTATUS:   data_o = mstatus_val;
      csr_pkg::CSR_MISA:      data_o = csr_pkg::MISA_VAL;
      csr_pkg::CSR_MIE:       data_o = state_i.mie;
      csr_pkg::CSR_MTVEC:     data_o = state_i.mtvec;
      csr_pkg::CSR_MSCRATCH:  data_o = state_i.mscratch;
      csr_pkg::CSR_MEPC:      data_o = state_i.mepc;
      csr_pkg::CSR_MCAUSE:    data_o = state_i.mcause;
      csr_pkg::CSR_MTVAL:     data_o = state_i.mtval;
      csr_pkg::CSR_MIP:       data_o = state_i.mip;
      // user-level counters alias the machine ones
      csr_pkg::CSR_MCYCLE,
      csr_pkg::CSR_CYCLE:     data_o = state_i.mcycle;
      csr_pkg::CSR_MINSTRET,
      csr_pkg::CSR_INSTRET:   data_o = state_i.minstret;
      csr_pkg::CSR_MHARTID:   data_o = hart_id_i;
      csr_pkg::CSR_MVENDORID,
      csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MIMPID:    data_o = '0;
      default:                data_o = '0;
    endcase
  end

endmodule

/* csr_write_stage.sv */
// CSR write staging
// holds a completed CSR write until its instruction commits or is flushed
`timescale 1ns/1ns

module csr_write_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                wr_en_i,
  input  csr_pkg::csr_write_t wr_i,
  input  logic                commit_i,
  input  logic                flush_i,
  output logic                cmt_we_o,
  output csr_pkg::csr_write_t cmt_o
);

  csr_pkg::csr_write_t staged;
  logic                pending;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      staged <= wr_i;
    end
  end

  // a new write wins over a flush in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (wr_en_i) begin
      pending <= 1'b1;
    end else if (flush_i || commit_i) begin
      pending <= 1'b0;
    end
  end

  // squashed writes never reach the architectural registers
  assign cmt_we_o = commit_i && pending;
  assign cmt_o    = staged;

endmodule

/* tb_csr_file.sv */
// testbench for the machine-mode CSR file
// checks staged writes, counters, traps, interrupts and the atomic read flag against a model
`timescale 1ns/1ns

module tb_csr_file;

  // the tests take about 155 cycles and the run is cut off at twice that
  localparam int TEST_CYCLES = 155;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic                clk;
  logic                reset;
  logic                wr_en_i;
  csr_pkg::csr_write_t wr_i;
  logic                commit_i;
  logic                flush_i;
  logic                rd_en_i;
  csr_pkg::csr_addr_t  rd_addr_i;
  logic [2:0]          retire_cnt_i;
  logic                exc_valid_i;
  csr_pkg::exc_info_t  exc_i;
  logic                mret_i;
  logic                irq_ext_i;
  logic                irq_soft_i;
  logic                irq_timer_i;
  csr_pkg::csr_data_t  hart_id_i;
  csr_pkg::csr_data_t  boot_vec_i;
  csr_pkg::csr_data_t  rd_data_o;
  logic                atomic_vio_o;
  logic                irq_pending_o;
  csr_pkg::csr_data_t  epc_o;
  csr_pkg::csr_data_t  evec_o;
  csr_pkg::priv_lvl_e  priv_o;

  // reference model of the architectural registers
  logic        m_st_mie;
  logic        m_st_mpie;
  logic [1:0]  m_st_mpp;
  logic [1:0]  m_priv;
  logic [63:0] m_mie;
  logic [63:0] m_mtvec;
  logic [63:0] m_mscratch;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mtval;

  integer      seed;
  integer      errors;
  integer      cycles;
  integer      i;
  integer      j;
  integer      rnd;
  logic [63:0] sum;
  logic [63:0] d;
  logic [63:0] v0;
  logic [63:0] v1;
  logic [63:0] v2;

  csr_file_top #(
    .RETIRE_CNT_W (3)
  ) i_dut (
    .clk           (clk),
    .reset         (reset),
    .wr_en_i       (wr_en_i),
    .wr_i          (wr_i),
    .commit_i      (commit_i),
    .flush_i       (flush_i),
    .rd_en_i       (rd_en_i),
    .rd_addr_i     (rd_addr_i),
    .retire_cnt_i  (retire_cnt_i),
    .exc_valid_i   (exc_valid_i),
    .exc_i         (exc_i),
    .mret_i        (mret_i),
    .irq_ext_i     (irq_ext_i),
    .irq_soft_i    (irq_soft_i),
    .irq_timer_i   (irq_timer_i),
    .hart_id_i     (hart_id_i),
    .boot_vec_i    (boot_vec_i),
    .rd_data_o     (rd_data_o),
    .atomic_vio_o  (atomic_vio_o),
    .irq_pending_o (irq_pending_o),
    .epc_o         (epc_o),
    .evec_o        (evec_o),
    .priv_o        (priv_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles, %0d errors",
               MAX_CYCLES, errors);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [63:0] rand64();
    rand64 = {$random(seed), $random(seed)};
  endfunction

  function automatic logic [63:0] mip_expect();
    logic [63:0] v;
    v     = '0;
    v[3]  = irq_soft_i;
    v[7]  = irq_timer_i;
    v[11] = irq_ext_i;
    return v;
  endfunction

  function automatic logic [63:0] csr_expect(input csr_pkg::csr_addr_t addr);
    logic [63:0] v;
    v = '0;
    case (addr)
      csr_pkg::CSR_MSTATUS: begin
        v[3]     = m_st_mie;
        v[7]     = m_st_mpie;
        v[12:11] = m_st_mpp;
      end
      // MXL = 2 in the top bits with I at bit 8 and M at bit 12
      csr_pkg::CSR_MISA:     v = 64'h8000_0000_0000_1100;
      csr_pkg::CSR_MIE:      v = m_mie;
      csr_pkg::CSR_MTVEC:    v = m_mtvec;
      csr_pkg::CSR_MSCRATCH: v = m_mscratch;
      csr_pkg::CSR_MEPC:     v = m_mepc;
      csr_pkg::CSR_MCAUSE:   v = m_mcause;
      csr_pkg::CSR_MTVAL:    v = m_mtval;
      csr_pkg::CSR_MIP:      v = mip_expect();
      csr_pkg::CSR_MHARTID:  v = hart_id_i;
      default:               v = '0;
    endcase
    return v;
  endfunction

  // M mode also needs mstatus.MIE while U mode takes any enabled interrupt
  function automatic logic pending_expect();
    return (|(m_mie & mip_expect())) && ((m_priv != 2'b11) || m_st_mie);
  endfunction

  task automatic apply_write(input csr_pkg::csr_addr_t addr, input logic [63:0] data);
    case (addr)
      csr_pkg::CSR_MSTATUS: begin
        m_st_mie  = data[3];
        m_st_mpie = data[7];
        m_st_mpp  = (data[12:11] == 2'b11) ? 2'b11 : 2'b00;
      end
      csr_pkg::CSR_MIE:      m_mie      = data & 64'h888;
      csr_pkg::CSR_MTVEC:    m_mtvec    = data & ~64'h2;
      csr_pkg::CSR_MSCRATCH: m_mscratch = data;
      csr_pkg::CSR_MEPC:     m_mepc     = data & ~64'h1;
      csr_pkg::CSR_MCAUSE:   m_mcause   = data;
      csr_pkg::CSR_MTVAL:    m_mtval    = data;
      default: ;
    endcase
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (act !== exp) begin
      errors = errors + 1;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic tick();
    @(negedge clk);
  endtask

  // each read samples mid-cycle before the rising edge of that cycle
  task automatic check_csr(input string name, input csr_pkg::csr_addr_t addr);
    rd_addr_i = addr;
    #1;
    check_value(name, csr_expect(addr), rd_data_o);
    @(negedge clk);
  endtask

  task automatic read_value(input csr_pkg::csr_addr_t addr, output logic [63:0] data);
    rd_addr_i = addr;
    #1;
    data = rd_data_o;
    @(negedge clk);
  endtask

  task automatic check_pending(input string name);
    #1;
    check_value(name, {63'b0, pending_expect()}, {63'b0, irq_pending_o});
    @(negedge clk);
  endtask

  task automatic check_vio(input string name, input logic exp);
    #1;
    check_value(name, {63'b0, exp}, {63'b0, atomic_vio_o});
    @(negedge clk);
  endtask

  task automatic commit_write(input csr_pkg::csr_addr_t addr, input logic [63:0] data);
    wr_en_i   = 1'b1;
    wr_i.addr = addr;
    wr_i.data = data;
    tick();
    wr_en_i  = 1'b0;
    commit_i = 1'b1;
    tick();
    commit_i = 1'b0;
    apply_write(addr, data);
  endtask

  task automatic take_trap(input logic [3:0] cause, input logic [63:0] pc,
                           input logic [63:0] ld_addr, input logic [63:0] st_addr);
    exc_valid_i   = 1'b1;
    exc_i.cause   = cause;
    exc_i.pc      = pc;
    exc_i.ld_addr = ld_addr;
    exc_i.st_addr = st_addr;
    tick();
    exc_valid_i = 1'b0;
    m_st_mpie   = m_st_mie;
    m_st_mie    = 1'b0;
    m_st_mpp    = m_priv;
    m_priv      = 2'b11;
    m_mepc      = pc;
    m_mcause    = {60'b0, cause};
    // fetch, load and store faults report their address and other causes keep mtval
    case (cause)
      4'd0, 4'd1: m_mtval = pc;
      4'd4, 4'd5: m_mtval = ld_addr;
      4'd6, 4'd7: m_mtval = st_addr;
      default: ;
    endcase
  endtask

  task automatic do_mret();
    mret_i = 1'b1;
    tick();
    mret_i    = 1'b0;
    m_priv    = m_st_mpp;
    m_st_mie  = m_st_mpie;
    m_st_mpie = 1'b1;
    m_st_mpp  = 2'b00;
  endtask

  task automatic staged_write_test(input string name, input csr_pkg::csr_addr_t addr);
    logic [63:0] data;
    data      = rand64();
    wr_en_i   = 1'b1;
    wr_i.addr = addr;
    wr_i.data = data;
    check_csr({name, " staged"}, addr);
    wr_en_i = 1'b0;
    check_csr({name, " pending"}, addr);
    commit_i = 1'b1;
    check_csr({name, " committing"}, addr);
    commit_i = 1'b0;
    apply_write(addr, data);
    check_csr({name, " committed"}, addr);
    // a flushed write must not land on a later commit
    wr_en_i   = 1'b1;
    wr_i.data = rand64();
    tick();
    wr_en_i = 1'b0;
    flush_i = 1'b1;
    tick();
    flush_i  = 1'b0;
    commit_i = 1'b1;
    tick();
    commit_i = 1'b0;
    check_csr({name, " flushed"}, addr);
  endtask

  initial begin
    seed         = 54;
    errors       = 0;
    cycles       = 0;
    reset        = 1'b1;
    wr_en_i      = 1'b0;
    wr_i         = '0;
    commit_i     = 1'b0;
    flush_i      = 1'b0;
    rd_en_i      = 1'b0;
    rd_addr_i    = '0;
    retire_cnt_i = '0;
    exc_valid_i  = 1'b0;
    exc_i        = '0;
    mret_i       = 1'b0;
    irq_ext_i    = 1'b0;
    irq_soft_i   = 1'b0;
    irq_timer_i  = 1'b0;
    hart_id_i    = 64'h0000_0000_0000_0005;
    boot_vec_i   = 64'h0000_0000_8000_0101;
    m_st_mie     = 1'b0;
    m_st_mpie    = 1'b0;
    m_st_mpp     = 2'b00;
    m_priv       = 2'b11;
    m_mie        = '0;
    m_mtvec      = boot_vec_i;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_mtval      = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // reset values
    check_value("reset priv", 64'd3, {62'b0, priv_o});
    check_value("reset evec", boot_vec_i & ~64'h3, evec_o);
    check_vio("reset atomic_vio", 1'b0);
    check_pending("reset irq_pending");
    check_csr("reset mtvec", csr_pkg::CSR_MTVEC);
    check_csr("reset mstatus", csr_pkg::CSR_MSTATUS);
    check_csr("reset mhartid", csr_pkg::CSR_MHARTID);
    check_csr("reset misa", csr_pkg::CSR_MISA);
    check_csr("reset mvendorid", csr_pkg::CSR_MVENDORID);

    staged_write_test("mscratch", csr_pkg::CSR_MSCRATCH);
    staged_write_test("mtvec", csr_pkg::CSR_MTVEC);
    staged_write_test("mepc", csr_pkg::CSR_MEPC);
    staged_write_test("mie", csr_pkg::CSR_MIE);

    // counters
    read_value(csr_pkg::CSR_MCYCLE, v0);
    repeat (6) tick();
    read_value(csr_pkg::CSR_MCYCLE, v1);
    check_value("mcycle interval", v0 + 64'd7, v1);
    read_value(csr_pkg::CSR_CYCLE, v2);
    check_value("cycle alias", v1 + 64'd1, v2);
    read_value(csr_pkg::CSR_MINSTRET, v0);
    sum = '0;
    for (i = 0; i < 8; i = i + 1) begin
      rnd          = $random(seed);
      retire_cnt_i = rnd[2:0];
      sum          = sum + {61'b0, rnd[2:0]};
      tick();
    end
    retire_cnt_i = '0;
    read_value(csr_pkg::CSR_MINSTRET, v1);
    check_value("minstret sum", v0 + sum, v1);
    read_value(csr_pkg::CSR_INSTRET, v2);
    check_value("instret alias", v1, v2);
    d = rand64();
    commit_write(csr_pkg::CSR_MCYCLE, d);
    read_value(csr_pkg::CSR_MCYCLE, v0);
    check_value("mcycle reload", d, v0);
    repeat (4) tick();
    read_value(csr_pkg::CSR_MCYCLE, v1);
    check_value("mcycle after reload", d + 64'd5, v1);

    // trap entry and mret alternate between U and M as the return mode
    for (i = 0; i < 4; i = i + 1) begin
      rnd = $random(seed);
      take_trap(rnd[3:0], rand64(), rand64(), rand64());
      check_value("trap priv", {62'b0, m_priv}, {62'b0, priv_o});
      check_value("trap evec", m_mtvec & ~64'h3, evec_o);
      check_value("trap epc", m_mepc, epc_o);
      check_csr("trap mepc", csr_pkg::CSR_MEPC);
      check_csr("trap mcause", csr_pkg::CSR_MCAUSE);
      check_csr("trap mtval", csr_pkg::CSR_MTVAL);
      check_csr("trap mstatus", csr_pkg::CSR_MSTATUS);
      commit_write(csr_pkg::CSR_MSTATUS, i[0] ? 64'h1880 : 64'h0080);
      do_mret();
      check_value("mret priv", {62'b0, m_priv}, {62'b0, priv_o});
      check_csr("mret mstatus", csr_pkg::CSR_MSTATUS);
    end

    // interrupts in M mode with mstatus.MIE off and on
    commit_write(csr_pkg::CSR_MIE, rand64() | 64'h888);
    for (i = 0; i < 3; i = i + 1) begin
      for (j = 0; j < 2; j = j + 1) begin
        commit_write(csr_pkg::CSR_MSTATUS, j[0] ? 64'h1808 : 64'h1800);
        irq_soft_i  = (i == 0);
        irq_timer_i = (i == 1);
        irq_ext_i   = (i == 2);
        check_csr("irq mip", csr_pkg::CSR_MIP);
        check_pending("irq_pending m mode");
      end
    end
    irq_soft_i = 1'b0;
    irq_ext_i  = 1'b0;
    commit_write(csr_pkg::CSR_MSTATUS, 64'h0);
    irq_timer_i = 1'b1;
    do_mret();
    check_pending("irq_pending u mode");
    commit_write(csr_pkg::CSR_MIE, 64'h0);
    check_pending("irq_pending masked");
    irq_timer_i = 1'b0;

    // read checkpointed at the edge where a new mscratch value commits
    wr_en_i   = 1'b1;
    wr_i.addr = csr_pkg::CSR_MSCRATCH;
    wr_i.data = m_mscratch ^ (rand64() | 64'h1);
    d         = wr_i.data;
    tick();
    wr_en_i  = 1'b0;
    rd_en_i  = 1'b1;
    commit_i = 1'b1;
    check_csr("atomic mscratch read", csr_pkg::CSR_MSCRATCH);
    rd_en_i  = 1'b0;
    commit_i = 1'b0;
    apply_write(csr_pkg::CSR_MSCRATCH, d);
    check_vio("atomic changed mscratch", 1'b1);
    commit_i = 1'b1;
    tick();
    commit_i = 1'b0;
    check_vio("atomic cleared by commit", 1'b0);
    rd_en_i = 1'b1;
    check_csr("atomic quiet read", csr_pkg::CSR_MSCRATCH);
    rd_en_i = 1'b0;
    check_vio("atomic unchanged mscratch", 1'b0);
    check_vio("atomic unchanged mscratch", 1'b0);
    rd_en_i = 1'b1;
    read_value(csr_pkg::CSR_MCYCLE, v0);
    rd_en_i = 1'b0;
    check_vio("atomic mcycle", 1'b1);
    check_vio("atomic mcycle", 1'b1);
    flush_i = 1'b1;
    tick();
    flush_i = 1'b0;
    check_vio("atomic cleared by flush", 1'b0);

    $display("checks done after %0d cycles, %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
